// File: svc_settings.svh
// Service controller settings with command and word widths, partition count and reset hold time.
`ifndef SVC_SETTINGS_SVH
`define SVC_SETTINGS_SVH

// ------------------------------
// Command port
// ------------------------------

// Width of one service command byte.
`define SVC_CMD_W 8

// ------------------------------
// Fault injection
// ------------------------------

// Number of partition words that can be corrupted.
`define SVC_NUM_PART 8

// Width of the word slice that is snapshotted and faulted.
`define SVC_WORD_W 16

// ------------------------------
// Subsystem reset
// ------------------------------

// Terminal count of the hold counter, so the reset stays low for SVC_RST_HOLD+1 cycles.
`define SVC_RST_HOLD 10
`define SVC_RST_CNT_W 4

`endif

// File: svc_cmd_pkg.sv
// Service command types: the opcode encoding and the decoded request handed to execute blocks.
`include "svc_settings.svh"

package svc_cmd_pkg;

  // Opcodes are grouped by the upper nibble.
  // 1x is reset, 2x is clock, 3x is assertion control and 4x is fault injection.
  typedef enum logic [`SVC_CMD_W-1:0] {
    RESET        = 8'h10,
    EN_RST_ZER   = 8'h11,
    DIS_RST_ZER  = 8'h12,
    CLK_500      = 8'h20,
    CLK_160      = 8'h21,
    CLK_400      = 8'h22,
    CLK_1000     = 8'h23,
    LC_SVA_DIS   = 8'h30,
    LC_SVA_EN    = 8'h31,
    FC_SVA_DIS   = 8'h32,
    FC_SVA_EN    = 8'h33,
    FAULT_CORR   = 8'h40,
    FAULT_UNCORR = 8'h41
  } svc_op_e;

  // One registered command.
  // At most one group bit is set, and none for an unknown opcode.
  typedef struct packed {
    logic    valid;
    svc_op_e op;
    logic    is_rst;
    logic    is_clk;
    logic    is_flag;
    logic    is_fault;
  } svc_req_t;

endpackage

// File: svc_cfg_pkg.sv
// Service configuration types: clock selection, fault kind and the status bundle.
package svc_cfg_pkg;

  // The 1000 MHz setting encodes as zero so it is the reset value.
  typedef enum logic [1:0] {
    MHZ_1000 = 2'd0,
    MHZ_500  = 2'd1,
    MHZ_400  = 2'd2,
    MHZ_160  = 2'd3
  } clk_sel_e;

  // Correctable flips a single bit and uncorrectable flips the whole word.
  typedef enum logic {
    CORR   = 1'b0,
    UNCORR = 1'b1
  } fault_kind_e;

  typedef struct packed {
    logic lc_sva_dis;
    logic fc_sva_dis;
    logic zer_armed;
    logic rst_busy;
    logic fault_active;
    logic ext_clk_req;
  } svc_status_t;

endpackage

// File: svc_cmd_decode.sv
// Service command decoder that accepts commands on a valid/ready port and registers a request.
module svc_cmd_decode
  import svc_cmd_pkg::*;
(
  input  logic     clk,
  input  logic     cptra_rst_b,
  input  logic     cmd_valid_i,
  input  svc_op_e  cmd_i,
  input  logic     rst_busy_i,
  output logic     cmd_ready_o,
  output svc_req_t req_o
);

  logic     accept;
  svc_req_t req_d;
  svc_req_t req_q;

  // Commands are refused while the subsystem reset pulse is running.
  assign cmd_ready_o = ~rst_busy_i;
  assign accept      = cmd_valid_i & cmd_ready_o;

  // ------------------------------
  // Group decode
  // ------------------------------
  always_comb begin
    req_d = '0;
    if (accept) begin
      req_d.valid = 1'b1;
      req_d.op    = cmd_i;
      case (cmd_i)
        RESET, EN_RST_ZER, DIS_RST_ZER: begin
          req_d.is_rst = 1'b1;
        end
        CLK_500, CLK_160, CLK_400, CLK_1000: begin
          req_d.is_clk = 1'b1;
        end
        LC_SVA_DIS, LC_SVA_EN, FC_SVA_DIS, FC_SVA_EN: begin
          req_d.is_flag = 1'b1;
        end
        FAULT_CORR, FAULT_UNCORR: begin
          req_d.is_fault = 1'b1;
        end
        default: begin
          // Unknown opcodes are consumed but reach no execute block.
        end
      endcase
    end
  end

  // The request lives for exactly one cycle after the transfer.
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      req_q <= '0;
    end else begin
      req_q <= req_d;
    end
  end

  assign req_o = req_q;

endmodule

// File: svc_reset_seq.sv
// Subsystem reset sequencer that drives a fixed-length active-low reset pulse.
`include "svc_settings.svh"

module svc_reset_seq
  import svc_cmd_pkg::*;
(
  input  logic     clk,
  input  logic     cptra_rst_b,
  input  svc_req_t req_i,
  input  logic     zer_write_i,
  output logic     sub_rst_b_o,
  output logic     busy_o,
  output logic     zer_armed_o
);

  logic                      rst_cmd;
  logic                      start;
  logic                      active_q;
  logic                      zer_armed_q;
  logic [`SVC_RST_CNT_W-1:0] cnt_q;

  assign rst_cmd = req_i.valid & req_i.is_rst;

  // A new pulse only starts from idle.
  // A direct command and an armed zeroization write are both start sources.
  assign start = ~active_q &
                 ((rst_cmd & (req_i.op == RESET)) | (zer_armed_q & zer_write_i));

  // ------------------------------
  // Reset-while-zeroizing arm flag
  // ------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      zer_armed_q <= 1'b0;
    end else if (rst_cmd) begin
      if (req_i.op == EN_RST_ZER) begin
        zer_armed_q <= 1'b1;
      end else if (req_i.op == DIS_RST_ZER) begin
        zer_armed_q <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Hold counter
  // ------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      // The pulse ends on the edge after the counter reaches its terminal value.
      if (cnt_q == `SVC_RST_HOLD) begin
        active_q <= 1'b0;
        cnt_q    <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign sub_rst_b_o = ~active_q;
  assign busy_o      = active_q;
  assign zer_armed_o = zer_armed_q;

endmodule

// File: svc_ctrl_regs.sv
// Clock selection and assertion-disable control registers.
module svc_ctrl_regs
  import svc_cmd_pkg::*;
  import svc_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     cptra_rst_b,
  input  svc_req_t req_i,
  input  logic     clk_byp_ack_i,
  output clk_sel_e clk_sel_o,
  output logic     clk_switch_req_o,
  output logic     ext_clk_req_o,
  output logic     lc_sva_dis_o,
  output logic     fc_sva_dis_o
);

  logic     clk_cmd;
  logic     flag_cmd;
  clk_sel_e clk_sel_d;
  clk_sel_e clk_sel_q;
  logic     ext_clk_req_q;
  logic     lc_sva_dis_q;
  logic     fc_sva_dis_q;

  assign clk_cmd  = req_i.valid & req_i.is_clk;
  assign flag_cmd = req_i.valid & req_i.is_flag;

  always_comb begin
    case (req_i.op)
      CLK_500: clk_sel_d = MHZ_500;
      CLK_160: clk_sel_d = MHZ_160;
      CLK_400: clk_sel_d = MHZ_400;
      default: clk_sel_d = MHZ_1000;
    endcase
  end

  // The switch is requested only once the bypass path has acknowledged.
  assign clk_switch_req_o = clk_byp_ack_i & ext_clk_req_q;

  // ------------------------------
  // Clock selection
  // ------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_q     <= MHZ_1000;
      ext_clk_req_q <= 1'b0;
    end else begin
      if (clk_switch_req_o) begin
        ext_clk_req_q <= 1'b0;
      end
      // A new selection wins over a clear in the same cycle.
      if (clk_cmd) begin
        clk_sel_q     <= clk_sel_d;
        ext_clk_req_q <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Assertion disable flags
  // ------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      lc_sva_dis_q <= 1'b0;
      fc_sva_dis_q <= 1'b0;
    end else if (flag_cmd) begin
      case (req_i.op)
        LC_SVA_DIS: lc_sva_dis_q <= 1'b1;
        LC_SVA_EN:  lc_sva_dis_q <= 1'b0;
        FC_SVA_DIS: fc_sva_dis_q <= 1'b1;
        FC_SVA_EN:  fc_sva_dis_q <= 1'b0;
        default:    lc_sva_dis_q <= lc_sva_dis_q;
      endcase
    end
  end

  assign clk_sel_o     = clk_sel_q;
  assign ext_clk_req_o = ext_clk_req_q;
  assign lc_sva_dis_o  = lc_sva_dis_q;
  assign fc_sva_dis_o  = fc_sva_dis_q;

endmodule

// File: svc_fault_inject.sv
// One-shot fault injector that snapshots partition words and overlays a corruption mask.
`include "svc_settings.svh"

module svc_fault_inject
  import svc_cmd_pkg::*;
  import svc_cfg_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       cptra_rst_b,
  input  svc_req_t                                   req_i,
  input  logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] part_word_i,
  output logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] part_word_o,
  output logic                                       fault_active_o
);

  localparam logic [`SVC_WORD_W-1:0] CorrMask = {{(`SVC_WORD_W-1){1'b0}}, 1'b1};

  logic                                       new_fault;
  logic                                       fault_active_q;
  fault_kind_e                                kind_q;
  logic [`SVC_WORD_W-1:0]                     mask;
  logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] snap_q;

  // Only the first fault request after reset is taken.
  assign new_fault = req_i.valid & req_i.is_fault & ~fault_active_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_active_q <= 1'b0;
      kind_q         <= CORR;
    end else if (new_fault) begin
      fault_active_q <= 1'b1;
      kind_q         <= (req_i.op == FAULT_UNCORR) ? UNCORR : CORR;
    end
  end

  // Clean copy of every partition word, taken on the fault edge.
  always_ff @(posedge clk) begin
    if (new_fault) begin
      snap_q <= part_word_i;
    end
  end

  assign mask = (kind_q == UNCORR) ? '1 : CorrMask;

  // ------------------------------
  // Per-partition output mux
  // ------------------------------
  for (genvar i = 0; i < `SVC_NUM_PART; i++) begin : g_part
    assign part_word_o[i] = fault_active_q ? (snap_q[i] ^ mask) : part_word_i[i];
  end

  assign fault_active_o = fault_active_q;

endmodule

// File: fc_lcc_svc_top.sv
// Fuse and life-cycle test-service controller top level.
`include "svc_settings.svh"

module fc_lcc_svc_top
  import svc_cmd_pkg::*;
  import svc_cfg_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       cptra_rst_b,
  input  logic                                       cmd_valid_i,
  input  svc_op_e                                    cmd_i,
  output logic                                       cmd_ready_o,
  input  logic                                       zer_write_i,
  input  logic                                       clk_byp_ack_i,
  input  logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] part_word_i,
  output logic                                       sub_rst_b_o,
  output clk_sel_e                                   clk_sel_o,
  output logic                                       clk_switch_req_o,
  output logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] part_word_o,
  output svc_status_t                                status_o
);

  svc_req_t req;
  logic     rst_busy;
  logic     zer_armed;
  logic     ext_clk_req;
  logic     lc_sva_dis;
  logic     fc_sva_dis;
  logic     fault_active;

  svc_cmd_decode u_decode (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .rst_busy_i  (rst_busy),
    .cmd_ready_o (cmd_ready_o),
    .req_o       (req)
  );

  svc_reset_seq u_reset_seq (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .req_i       (req),
    .zer_write_i (zer_write_i),
    .sub_rst_b_o (sub_rst_b_o),
    .busy_o      (rst_busy),
    .zer_armed_o (zer_armed)
  );

  svc_ctrl_regs u_ctrl_regs (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .req_i            (req),
    .clk_byp_ack_i    (clk_byp_ack_i),
    .clk_sel_o        (clk_sel_o),
    .clk_switch_req_o (clk_switch_req_o),
    .ext_clk_req_o    (ext_clk_req),
    .lc_sva_dis_o     (lc_sva_dis),
    .fc_sva_dis_o     (fc_sva_dis)
  );

  svc_fault_inject u_fault_inject (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .req_i          (req),
    .part_word_i    (part_word_i),
    .part_word_o    (part_word_o),
    .fault_active_o (fault_active)
  );

  // Status gathered from all execute blocks.
  assign status_o.lc_sva_dis   = lc_sva_dis;
  assign status_o.fc_sva_dis   = fc_sva_dis;
  assign status_o.zer_armed    = zer_armed;
  assign status_o.rst_busy     = rst_busy;
  assign status_o.fault_active = fault_active;
  assign status_o.ext_clk_req  = ext_clk_req;

endmodule

// File: svc_assert.sv
// Concurrent checks on reset, clock switch and fault outputs of the service controller.
module svc_assert (
  input logic clk,
  input logic cptra_rst_b,
  input logic cmd_ready_i,
  input logic sub_rst_b_i,
  input logic clk_switch_req_i,
  input logic clk_byp_ack_i,
  input logic fault_active_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of property failures seen so far.
  int unsigned fail_cnt = 0;

  // ------------------------------
  // Handshake and clock switch
  // ------------------------------

  // No command may be taken while the subsystem is held in reset.
  a_rst_blocks_cmd: assert property (
    @(posedge clk) disable iff (!cptra_rst_b) !sub_rst_b_i |-> !cmd_ready_i
  ) else begin
    fail_cnt++;
    $error("cmd_ready_o high while sub_rst_b_o is low");
  end

  a_switch_needs_ack: assert property (
    @(posedge clk) disable iff (!cptra_rst_b) clk_switch_req_i |-> clk_byp_ack_i
  ) else begin
    fail_cnt++;
    $error("clk_switch_req_o high without clk_byp_ack_i");
  end

  // ------------------------------
  // Fault injection
  // ------------------------------

  // Once injected, a fault stays until the next reset.
  a_fault_sticky: assert property (
    @(posedge clk) disable iff (!cptra_rst_b) !$fell(fault_active_i)
  ) else begin
    fail_cnt++;
    $error("fault_active fell without a reset");
  end

endmodule

// File: tb_fc_lcc_svc.sv
// Directed testbench for the fuse and life-cycle test-service controller.
`include "svc_settings.svh"

module tb_fc_lcc_svc
  import svc_cmd_pkg::*;
  import svc_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CmdTimeout = 50;

  logic                                       clk;
  logic                                       cptra_rst_b;
  logic                                       cmd_valid_i;
  svc_op_e                                    cmd_i;
  logic                                       cmd_ready_o;
  logic                                       zer_write_i;
  logic                                       clk_byp_ack_i;
  logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] part_word_i;
  logic                                       sub_rst_b_o;
  clk_sel_e                                   clk_sel_o;
  logic                                       clk_switch_req_o;
  logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] part_word_o;
  svc_status_t                                status_o;
  integer                                     seed;

  fc_lcc_svc_top dut0 (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .cmd_ready_o      (cmd_ready_o),
    .zer_write_i      (zer_write_i),
    .clk_byp_ack_i    (clk_byp_ack_i),
    .part_word_i      (part_word_i),
    .sub_rst_b_o      (sub_rst_b_o),
    .clk_sel_o        (clk_sel_o),
    .clk_switch_req_o (clk_switch_req_o),
    .part_word_o      (part_word_o),
    .status_o         (status_o)
  );

  bind fc_lcc_svc_top svc_assert u_svc_assert (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_ready_i      (cmd_ready_o),
    .sub_rst_b_i      (sub_rst_b_o),
    .clk_switch_req_i (clk_switch_req_o),
    .clk_byp_ack_i    (clk_byp_ack_i),
    .fault_active_i   (status_o.fault_active)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // Checking and driving helpers
  // ------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    cptra_rst_b   <= 1'b0;
    cmd_valid_i   <= 1'b0;
    zer_write_i   <= 1'b0;
    clk_byp_ack_i <= 1'b0;
    repeat (8) @(posedge clk);
    cptra_rst_b <= 1'b1;
    @(negedge clk);
    check("cmd_ready_o", 128'(cmd_ready_o), 128'd1);
    check("sub_rst_b_o", 128'(sub_rst_b_o), 128'd1);
    check("status_o", 128'(status_o), 128'd0);
    check("clk_sel_o", 128'(clk_sel_o), 128'(MHZ_1000));
  endtask

  // Returns at the transfer edge, with valid already dropped for the next cycle.
  task automatic send_cmd(input svc_op_e op);
    int waited;
    waited = 0;
    @(posedge clk);
    cmd_valid_i <= 1'b1;
    cmd_i       <= op;
    @(negedge clk);
    while (!cmd_ready_o) begin
      if (waited == CmdTimeout) begin
        abort_run("Timeout: cmd_ready_o never went high for a pending command");
      end
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    cmd_valid_i <= 1'b0;
  endtask

  // A command acts on the second edge after its transfer.
  task automatic wait_effect();
    @(negedge clk);
    @(negedge clk);
  endtask

  task automatic load_words(output logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] w);
    logic [31:0] rnd;
    for (int i = 0; i < `SVC_NUM_PART; i++) begin
      rnd  = $random(seed);
      w[i] = rnd[`SVC_WORD_W-1:0];
    end
    @(posedge clk);
    part_word_i <= w;
  endtask

  task automatic pulse_zer_write();
    @(posedge clk);
    zer_write_i <= 1'b1;
    @(posedge clk);
    zer_write_i <= 1'b0;
  endtask

  task automatic expect_reset_pulse();
    repeat (`SVC_RST_HOLD + 1) begin
      @(negedge clk);
      check("sub_rst_b_o", 128'(sub_rst_b_o), 128'd0);
      check("cmd_ready_o", 128'(cmd_ready_o), 128'd0);
      check("status_o.rst_busy", 128'(status_o.rst_busy), 128'd1);
    end
    @(negedge clk);
    check("sub_rst_b_o", 128'(sub_rst_b_o), 128'd1);
    check("cmd_ready_o", 128'(cmd_ready_o), 128'd1);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_reset_cmd();
    send_cmd(RESET);
    @(negedge clk);
    check("sub_rst_b_o", 128'(sub_rst_b_o), 128'd1);
    expect_reset_pulse();
  endtask

  task automatic test_clock_select();
    svc_op_e  ops [4] = '{CLK_500, CLK_160, CLK_400, CLK_1000};
    clk_sel_e sels [4] = '{MHZ_500, MHZ_160, MHZ_400, MHZ_1000};
    for (int i = 0; i < 4; i++) begin
      send_cmd(ops[i]);
      wait_effect();
      check("clk_sel_o", 128'(clk_sel_o), 128'(sels[i]));
      check("status_o.ext_clk_req", 128'(status_o.ext_clk_req), 128'd1);
      check("clk_switch_req_o", 128'(clk_switch_req_o), 128'd0);
      @(posedge clk);
      clk_byp_ack_i <= 1'b1;
      @(negedge clk);
      check("clk_switch_req_o", 128'(clk_switch_req_o), 128'd1);
      // The request drops on the edge after the switch is seen.
      @(negedge clk);
      check("status_o.ext_clk_req", 128'(status_o.ext_clk_req), 128'd0);
      check("clk_switch_req_o", 128'(clk_switch_req_o), 128'd0);
      @(posedge clk);
      clk_byp_ack_i <= 1'b0;
    end
  endtask

  task automatic test_sva_flags();
    logic [10:0]  ctrl_before;
    logic [127:0] words_before;
    send_cmd(LC_SVA_DIS);
    wait_effect();
    check("status_o.lc_sva_dis", 128'(status_o.lc_sva_dis), 128'd1);
    check("status_o.fc_sva_dis", 128'(status_o.fc_sva_dis), 128'd0);
    send_cmd(FC_SVA_DIS);
    wait_effect();
    check("status_o.fc_sva_dis", 128'(status_o.fc_sva_dis), 128'd1);
    send_cmd(LC_SVA_EN);
    wait_effect();
    check("status_o.lc_sva_dis", 128'(status_o.lc_sva_dis), 128'd0);
    check("status_o.fc_sva_dis", 128'(status_o.fc_sva_dis), 128'd1);
    // An opcode outside the command set is taken but leaves every output alone.
    ctrl_before  = {status_o, clk_sel_o, clk_switch_req_o, sub_rst_b_o, cmd_ready_o};
    words_before = part_word_o;
    send_cmd(svc_op_e'(8'h5a));
    wait_effect();
    check("control outputs", 128'({status_o, clk_sel_o, clk_switch_req_o, sub_rst_b_o,
                                   cmd_ready_o}), 128'(ctrl_before));
    check("part_word_o", 128'(part_word_o), words_before);
    send_cmd(FC_SVA_EN);
    wait_effect();
    check("status_o.fc_sva_dis", 128'(status_o.fc_sva_dis), 128'd0);
  endtask

  task automatic test_fault_inject();
    logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] words;
    logic [`SVC_NUM_PART-1:0][`SVC_WORD_W-1:0] faulted;
    load_words(words);
    @(negedge clk);
    check("part_word_o", 128'(part_word_o), 128'(words));
    send_cmd(FAULT_CORR);
    wait_effect();
    for (int i = 0; i < `SVC_NUM_PART; i++) begin
      faulted[i] = words[i] ^ `SVC_WORD_W'(1);
    end
    check("part_word_o", 128'(part_word_o), 128'(faulted));
    check("status_o.fault_active", 128'(status_o.fault_active), 128'd1);
    // New input words and a second fault must not disturb the held snapshot.
    load_words(words);
    send_cmd(FAULT_UNCORR);
    wait_effect();
    check("part_word_o", 128'(part_word_o), 128'(faulted));
    apply_reset();
    load_words(words);
    @(negedge clk);
    check("part_word_o", 128'(part_word_o), 128'(words));
    send_cmd(FAULT_UNCORR);
    wait_effect();
    check("part_word_o", 128'(part_word_o), ~128'(words));
  endtask

  task automatic test_zeroize_reset();
    send_cmd(EN_RST_ZER);
    wait_effect();
    check("status_o.zer_armed", 128'(status_o.zer_armed), 128'd1);
    check("sub_rst_b_o", 128'(sub_rst_b_o), 128'd1);
    pulse_zer_write();
    expect_reset_pulse();
    send_cmd(DIS_RST_ZER);
    wait_effect();
    check("status_o.zer_armed", 128'(status_o.zer_armed), 128'd0);
    pulse_zer_write();
    repeat (`SVC_RST_HOLD + 3) begin
      @(negedge clk);
      check("sub_rst_b_o", 128'(sub_rst_b_o), 128'd1);
    end
  endtask

  initial begin
    seed          = 32'h054e_777d;
    clk           = 1'b0;
    cptra_rst_b   = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_i         = RESET;
    zer_write_i   = 1'b0;
    clk_byp_ack_i = 1'b0;
    part_word_i   = '0;
    apply_reset();
    test_reset_cmd();
    test_clock_select();
    test_sva_flags();
    test_fault_inject();
    test_zeroize_reset();
    if (dut0.u_svc_assert.fail_cnt != 0) begin
      abort_run("Concurrent assertions failed during the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+.
svc_cmd_pkg.sv
svc_cfg_pkg.sv
svc_cmd_decode.sv
svc_reset_seq.sv
svc_ctrl_regs.sv
svc_fault_inject.sv
fc_lcc_svc_top.sv
svc_assert.sv
tb_fc_lcc_svc.sv

// File: Makefile
# Verilator build and run for the test-service controller testbench.

VERILATOR ?= verilator
TOP       ?= tb_fc_lcc_svc
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
